// File: rtl/fpuAddNorm.sv
// **********************************************************
// Stages 2 and 3 of the add unit.
// Adds the aligned fractions into a magnitude and sign, then
// normalizes with a leading-zero count and exponent adjust.
// **********************************************************
`timescale 1ns/100ps

module fpuAddNorm import fpuPkg::*;
(
	input  logic      clock,
	input  logic      rstN,
	input  alignStage s2,
	output packStage  s4
);

	sumStage     s3;
	sumStage     sumNxt;
	packStage    packNxt;

	logic        same;
	logic [64:0] sumWide;
	logic        neg;

	logic [6:0]  lz;
	logic [1:0]  up;
	logic [6:0]  down;
	logic [11:0] expWide;
	logic        signA;

	// leading zeros of a 64-bit value, 64 when all zero
	function automatic logic [6:0] countLz(input logic [63:0] v);
		logic [6:0] n;
		logic       found;
		n = 7'd0;
		found = 1'b0;
		for (int i = 63; i >= 0; i--)
		begin
			if (!found)
			begin
				if (v[i])
					found = 1'b1;
				else
					n = n + 7'd1;
			end
		end
		return n;
	endfunction

	// stage 2, signed add
	always_comb
	begin
		same = (s2.signA == s2.signB);
		if (same)
			sumWide = {1'b0, s2.fraA} + {1'b0, s2.fraB};
		else
			sumWide = {1'b0, s2.fraA} - {1'b0, s2.fraB};
		// borrow out means B was the bigger one
		neg = !same && sumWide[64];

		sumNxt.valid = s2.valid;
		sumNxt.op = s2.op;
		sumNxt.sign = s2.signA ^ neg;
		sumNxt.exp = s2.expA;
		sumNxt.fra = neg ? -sumWide[63:0] : sumWide[63:0];
		sumNxt.raw = sumWide[63:0];
	end

	// stage 3, normalize so the leading one sits on bit 61
	always_comb
	begin
		lz = countLz(s3.fra);
		up = (lz == 7'd0) ? 2'd2 : 2'd1;
		down = lz - 7'd2;

		packNxt.valid = s3.valid;
		packNxt.op = s3.op;
		packNxt.sign = s3.sign;
		packNxt.exp = s3.exp;
		packNxt.fra = s3.fra;
		packNxt.shift = 7'd0;
		packNxt.isZero = 1'b0;

		if (lz < 7'd2)
		begin
			// carry out, move right
			expWide = {1'b0, s3.exp} + {10'd0, up};
			packNxt.fra = s3.fra >> up;
			packNxt.exp = expWide[10:0];
			if (expWide >= 12'd2047)
			begin
				// overflow to infinity
				packNxt.exp = 11'd2047;
				packNxt.fra = '0;
			end
		end
		else
		begin
			expWide = {1'b0, s3.exp} - {5'd0, down};
			packNxt.exp = expWide[10:0];
			packNxt.shift = down;
			if (lz == 7'd64 || expWide[11] || expWide == 12'd0)
			begin
				packNxt.isZero = 1'b1;
				packNxt.sign = 1'b0;
				packNxt.exp = 11'd0;
			end
		end

		// F2I: sign of the larger operand goes back on the raw sum
		signA = s3.sign ^ s3.raw[63];
		packNxt.intRes = signA ? -s3.raw : s3.raw;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			s3.valid <= 1'b0;
			s4.valid <= 1'b0;
		end
		else
		begin
			s3 <= sumNxt;
			s4 <= packNxt;
		end
	end

endmodule

// File: rtl/fpuAddUnit.sv
// **********************************************************
// Double-precision add unit for the execute stage.
// Four-stage pipeline for add, subtract, I2F and F2I with
// round toward zero. A result appears four cycles after the
// request, as a single valid pulse.
// **********************************************************
`timescale 1ns/100ps

module fpuAddUnit import fpuPkg::*;
(
	input  logic     clock,
	input  logic     rstN,
	input  logic     hold,
	input  fpuReq    req,
	output fpuResult result
);

	alignStage s2;
	packStage  s4;

	// unpack and align
	fpuAlign align
	(
		.clock (clock),
		.rstN  (rstN),
		.hold  (hold),
		.req   (req),
		.s2    (s2)
	);

	// add, then normalize
	fpuAddNorm addNorm
	(
		.clock (clock),
		.rstN  (rstN),
		.s2    (s2),
		.s4    (s4)
	);

	// pack the result word
	fpuPack pack
	(
		.clock  (clock),
		.rstN   (rstN),
		.s4     (s4),
		.result (result)
	);

endmodule

// File: rtl/fpuAlign.sv
// **********************************************************
// Stage 1 of the add unit.
// Unpacks both operands, orders them by exponent and shifts
// the smaller fraction right. Takes a request when hold is low.
// **********************************************************
`timescale 1ns/100ps

module fpuAlign import fpuPkg::*;
(
	input  logic      clock,
	input  logic      rstN,
	input  logic      hold,
	input  fpuReq     req,
	output alignStage s2
);

	logic               accept;
	logic               rnSign;
	logic               rmSign;
	logic [10:0]        rnExp;
	logic [10:0]        rmExp;
	logic [FraBits-1:0] rnFra;
	logic [FraBits-1:0] rmFra;
	logic [63:0]        intMag;

	logic               sA;
	logic               sB;
	logic [10:0]        eA;
	logic [10:0]        eB;
	logic [FraBits-1:0] fA;
	logic [FraBits-1:0] fB;

	logic               swap;
	logic [10:0]        expDiff;
	logic [FraBits-1:0] fraSmall;
	alignStage          nxt;

	assign accept = !hold && (req.op != opNone);

	always_comb
	begin
		rnSign = req.rn[63];
		rmSign = req.rm[63];
		rnExp = req.rn[62:52];
		rmExp = req.rm[62:52];
		// hidden one only for a nonzero exponent, denormals read as zero
		rnFra = (rnExp != 11'd0) ? {3'b001, req.rn[51:0], 9'h000} : '0;
		rmFra = (rmExp != 11'd0) ? {3'b001, req.rm[51:0], 9'h000} : '0;
		intMag = rnSign ? -req.rn : req.rn;

		case (req.op)
			opI2F:
			begin
				sA = rnSign;
				eA = 11'(IntExp);
				fA = intMag;
				sB = 1'b0;
				eB = 11'(IntExp);
				fB = '0;
			end
			opF2I:
			begin
				// add to zero at the integer exponent
				sA = rnSign;
				eA = rnExp;
				fA = rnFra;
				sB = 1'b0;
				eB = 11'(IntExp);
				fB = '0;
			end
			default:
			begin
				sA = rnSign;
				eA = rnExp;
				fA = rnFra;
				sB = rmSign ^ (req.op == opSub);
				eB = rmExp;
				fB = rmFra;
			end
		endcase

		// ties keep rn as the larger operand
		swap = eB > eA;
		expDiff = swap ? (eB - eA) : (eA - eB);
		fraSmall = swap ? fA : fB;

		nxt.valid = accept;
		nxt.op = req.op;
		nxt.signA = swap ? sB : sA;
		nxt.signB = swap ? sA : sB;
		nxt.expA = swap ? eB : eA;
		nxt.fraA = swap ? fB : fA;
		// shifts of 64 or more clear the fraction
		nxt.fraB = (expDiff >= 11'd64) ? '0 : (fraSmall >> expDiff[5:0]);
		nxt.intVal = req.rn;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			s2.valid <= 1'b0;
		end
		else if (accept)
		begin
			s2 <= nxt;
		end
		else
		begin
			s2.valid <= 1'b0;
		end
	end

endmodule

// File: rtl/fpuPack.sv
// **********************************************************
// Stage 4 of the add unit.
// Shifts out leading zeros, truncates to 52 fraction bits and
// packs the binary64 word, or passes the F2I integer through.
// **********************************************************
`timescale 1ns/100ps

module fpuPack import fpuPkg::*;
(
	input  logic     clock,
	input  logic     rstN,
	input  packStage s4,
	output fpuResult result
);

	logic [FraBits-1:0] fraNorm;
	fpuResult           resNxt;

	always_comb
	begin
		fraNorm = s4.fra << s4.shift;

		resNxt.valid = s4.valid;
		// hidden one on bit 61 is dropped, bits below 9 truncated
		resNxt.value = {s4.sign, s4.exp, fraNorm[60:9]};

		if (s4.isZero)
			resNxt.value = 64'd0;

		if (s4.op == opF2I)
			resNxt.value = s4.intRes;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			result.valid <= 1'b0;
		end
		else
		begin
			result <= resNxt;
		end
	end

endmodule

// File: rtl/fpuPkg.sv
// **********************************************************
// Shared types of the double-precision add unit.
// Opcodes, the request and result words, and the structs
// carried between the pipeline stages.
// **********************************************************

package fpuPkg;

	// working fraction: bit 62 carry, bit 61 hidden one, 9 guard bits below
	localparam int FraBits = 64;
	localparam int ExpBias = 1023;
	// integer lsb lands on bit 0 of the working fraction
	localparam int IntExp = ExpBias + 61;

	typedef enum logic [2:0] {
		opNone = 3'd0,
		opAdd  = 3'd1,
		opSub  = 3'd2,
		opI2F  = 3'd3,
		opF2I  = 3'd4
	} fpuOp;

	typedef struct packed {
		fpuOp        op;
		logic [63:0] rn;
		logic [63:0] rm;
	} fpuReq;

	// stage 1 to stage 2, operand A has the larger exponent
	typedef struct packed {
		logic               valid;
		fpuOp               op;
		logic               signA;
		logic               signB;
		logic [10:0]        expA;
		logic [FraBits-1:0] fraA;
		logic [FraBits-1:0] fraB;
		logic [63:0]        intVal;
	} alignStage;

	// stage 2 to stage 3
	typedef struct packed {
		logic               valid;
		fpuOp               op;
		logic               sign;
		logic [10:0]        exp;
		logic [FraBits-1:0] fra;
		logic [63:0]        raw;
	} sumStage;

	// stage 3 to stage 4
	typedef struct packed {
		logic               valid;
		fpuOp               op;
		logic               sign;
		logic [10:0]        exp;
		logic [FraBits-1:0] fra;
		logic [6:0]         shift;
		logic               isZero;
		logic [63:0]        intRes;
	} packStage;

	typedef struct packed {
		logic        valid;
		logic [63:0] value;
	} fpuResult;

endpackage

// File: run.sh
#!/usr/bin/env bash
# builds the add unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sim.f --top-module fpuAddTb -o simFpuAdd
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simFpuAdd > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulator exited with status $simStatus"
	exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// File: sim.f
rtl/fpuPkg.sv
rtl/fpuAlign.sv
rtl/fpuAddNorm.sv
rtl/fpuPack.sv
rtl/fpuAddUnit.sv
test/fpuAddTb.sv

// File: test/fpuAddTb.sv
// **********************************************************
// Testbench for the double-precision add unit.
// Drives add, sub, I2F and F2I requests with hold and idle
// cycles, and checks each result against a real-number model.
// **********************************************************
`timescale 1ns/100ps

module fpuAddTb import fpuPkg::*;
();

	localparam int ClockPeriod = 20;
	localparam int DriveDelay = 2;
	localparam int Latency = 4;
	localparam int NumIdle = 5;
	localparam int NumAdd = 40;
	localparam int NumSub = 30;
	localparam int NumI2F = 30;
	localparam int NumF2I = 30;
	localparam int HoldPre = 3;
	localparam int HoldLen = 6;
	localparam int HoldPost = 3;
	localparam int NumMix = 40;
	localparam int TotalSlots = NumIdle + NumAdd + NumSub + NumI2F + NumF2I
		+ HoldPre + HoldLen + HoldPost + NumMix;
	localparam int WatchdogCycles = TotalSlots * 2 + 100;

	typedef struct packed {
		logic [63:0] value;
		logic [31:0] cycle;
	} expectEntry;

	logic        clock;
	logic        rstN;
	logic        hold;
	fpuReq       req;
	fpuResult    result;
	logic [31:0] cycle = 32'd0;
	logic [31:0] rngState = 32'h7b6f_f4b5;
	expectEntry  expQ[$];

	fpuAddUnit DUT
	(
		.clock  (clock),
		.rstN   (rstN),
		.hold   (hold),
		.req    (req),
		.result (result)
	);

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	always @(posedge clock)
		cycle <= cycle + 32'd1;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped on the first error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic nextWord(output logic [31:0] w);
		rngState = xorshift32(rngState);
		w = rngState;
	endtask

	// integer-valued double below 2^40, random sign and size
	task automatic randIntDouble(output logic [63:0] bits);
		logic [31:0] a;
		logic [31:0] b;
		logic [39:0] mag;
		longint      v;
		real         x;
		nextWord(a);
		nextWord(b);
		mag = {a[7:0], b} >> a[13:9];
		v = {24'd0, mag};
		if (a[31])
			v = -v;
		x = v;
		bits = $realtobits(x);
	endtask

	// two's complement integer below 2^52
	task automatic randInt52(input logic neg, output logic [63:0] bits);
		logic [31:0] a;
		logic [31:0] b;
		logic [51:0] mag;
		longint      v;
		nextWord(a);
		nextWord(b);
		mag = {a[19:0], b} >> a[25:20];
		v = {12'd0, mag};
		if (neg)
			v = -v;
		bits = v;
	endtask

	// multiple of 0.25 below 2^20, or a whole number
	task automatic randQuarter(input logic integral, output logic [63:0] bits);
		logic [31:0] a;
		logic [19:0] k;
		logic [1:0]  q;
		longint      n;
		real         x;
		nextWord(a);
		k = a[19:0] >> a[24:20];
		q = integral ? 2'b00 : a[31:30];
		n = {42'd0, k, q};
		x = n;
		x = x / 4.0;
		if (a[29])
			x = -x;
		bits = $realtobits(x);
	endtask

	// expected result word, exact for the operands chosen above
	function automatic logic [63:0] refResult(input fpuReq r);
		longint iv;
		real    x;
		case (r.op)
			opAdd: return $realtobits($bitstoreal(r.rn) + $bitstoreal(r.rm));
			opSub: return $realtobits($bitstoreal(r.rn) - $bitstoreal(r.rm));
			opI2F:
			begin
				iv = r.rn;
				x = iv;
				return $realtobits(x);
			end
			opF2I:
			begin
				// rtoi truncates toward zero
				iv = $rtoi($bitstoreal(r.rn));
				return iv;
			end
			default: return 64'd0;
		endcase
	endfunction

	task automatic drive(input fpuOp op, input logic [63:0] rn, input logic [63:0] rm,
		input logic held);
		fpuReq      r;
		expectEntry e;
		@(posedge clock);
		#DriveDelay;
		r.op = op;
		r.rn = rn;
		r.rm = rm;
		req = r;
		hold = held;
		if (!held && op != opNone)
		begin
			e.value = refResult(r);
			e.cycle = cycle;
			expQ.push_back(e);
		end
	endtask

	// result shows four cycles after the drive cycle
	always @(negedge clock)
	begin
		expectEntry e;
		if (rstN && result.valid)
		begin
			assert (expQ.size() != 0)
			else
				abortRun("result.valid pulsed with no request outstanding");
			if (expQ.size() != 0)
			begin
				e = expQ.pop_front();
				assert (result.value == e.value)
				else
					abortRun($sformatf("[ERROR] result.value expected %h got %h",
						e.value, result.value));
				assert (cycle == e.cycle + Latency)
				else
					abortRun($sformatf("result arrived in cycle %0d instead of cycle %0d",
						cycle, e.cycle + Latency));
			end
		end
	end

	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		abortRun("watchdog expired before all results came back");
	end

	initial
	begin
		logic [63:0] a;
		logic [63:0] b;
		logic [31:0] w;
		rstN = 1'b0;
		hold = 1'b0;
		req.op = opNone;
		req.rn = 64'd0;
		req.rm = 64'd0;
		repeat (4) @(posedge clock);
		#DriveDelay;
		rstN = 1'b1;

		repeat (NumIdle) drive(opNone, 64'd0, 64'd0, 1'b0);

		// back-to-back adds
		for (int i = 0; i < NumAdd; i++)
		begin
			randIntDouble(a);
			randIntDouble(b);
			drive(opAdd, a, b, 1'b0);
		end

		// every fifth pair is equal, so the difference is +0
		for (int i = 0; i < NumSub; i++)
		begin
			randIntDouble(a);
			randIntDouble(b);
			if (i % 5 == 0)
				b = a;
			else if (i % 5 == 1 && a[62:52] != 11'd0)
			begin
				// same exponent, rm one ulp larger, so the difference changes sign
				b = a | 64'd1;
			end
			drive(opSub, a, b, 1'b0);
		end

		for (int i = 0; i < NumI2F; i++)
		begin
			randInt52(i % 2 == 1, a);
			if (i == 0)
				a = 64'd0;
			drive(opI2F, a, 64'd0, 1'b0);
		end

		for (int i = 0; i < NumF2I; i++)
		begin
			randQuarter(i % 4 == 0, a);
			drive(opF2I, a, 64'd0, 1'b0);
		end

		// in-flight adds finish while hold blocks new ones
		for (int i = 0; i < HoldPre + HoldLen + HoldPost; i++)
		begin
			randIntDouble(a);
			randIntDouble(b);
			drive(opAdd, a, b, i >= HoldPre && i < HoldPre + HoldLen);
		end

		// all ops mixed with idle cycles
		for (int i = 0; i < NumMix; i++)
		begin
			nextWord(w);
			randIntDouble(a);
			randIntDouble(b);
			if (w[0])
				drive(opNone, a, b, 1'b0);
			else
			begin
				case (w[2:1])
					2'd0: drive(opAdd, a, b, 1'b0);
					2'd1: drive(opSub, a, b, 1'b0);
					2'd2:
					begin
						randInt52(w[3], a);
						drive(opI2F, a, 64'd0, 1'b0);
					end
					default:
					begin
						randQuarter(w[4], a);
						drive(opF2I, a, 64'd0, 1'b0);
					end
				endcase
			end
		end

		drive(opNone, 64'd0, 64'd0, 1'b0);
		while (expQ.size() != 0)
			@(posedge clock);
		// a few more cycles to catch a stray pulse
		repeat (Latency) @(posedge clock);
		$display("STATUS: PASS");
		$finish;
	end

endmodule
